// ==== machine_pkg.sv ====
package machine_pkg;

    // register width of the core this unit serves
    localparam int xlen = 32;

    // mtvec value after reset
    localparam logic [xlen-1:0] default_trap_vector = 32'h0000_0100;

    // csr addresses as seen on the apb bus
    localparam logic [11:0] csr_mstatus   = 12'h300;
    localparam logic [11:0] csr_mie       = 12'h304;
    localparam logic [11:0] csr_mtvec     = 12'h305;
    localparam logic [11:0] csr_mscratch  = 12'h340;
    localparam logic [11:0] csr_mepc      = 12'h341;
    localparam logic [11:0] csr_mcause    = 12'h342;
    localparam logic [11:0] csr_mip       = 12'h344;
    localparam logic [11:0] csr_mtimecmp  = 12'h7C1;
    localparam logic [11:0] csr_mtimecmph = 12'h7C2;
    localparam logic [11:0] csr_cycle     = 12'hC00;
    localparam logic [11:0] csr_cycleh    = 12'hC80;

    // bit positions inside mstatus, mie and mip
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int meie_bit         = 11;
    localparam int mtie_bit         = 7;

    // interrupt cause codes, flag sits in the top bit of mcause
    localparam logic [3:0] cause_mei = 4'd11;
    localparam logic [3:0] cause_mti = 4'd7;
    localparam int interrupt_bit = 31;

    typedef struct packed {
        logic       interrupt;
        logic [3:0] code;
    } cause_t;

    // what the core reports each cycle
    typedef struct packed {
        logic            exception_valid;
        logic [3:0]      exception_code;
        logic            mret;
        logic [xlen-1:0] pc;
    } core_event_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } redirect_t;

    // trap entry and exit as seen by the csr storage
    typedef struct packed {
        logic            enter;
        logic            leave;
        cause_t          cause;
        logic [xlen-1:0] epc;
    } trap_update_t;

    typedef enum logic [1:0] {
        run,
        handler,
        locked
    } trap_state_t;

endpackage

// ==== apb_pkg.sv ====
package apb_pkg;

    // bus widths
    localparam int apb_addr_width = 12;
    localparam int apb_data_width = 32;

    // requester side of one apb link
    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [apb_addr_width-1:0] paddr;
        logic [apb_data_width-1:0] pwdata;
    } apb_req_t;

    // completer side, pready is always high here
    typedef struct packed {
        logic                      pready;
        logic                      pslverr;
        logic [apb_data_width-1:0] prdata;
    } apb_rsp_t;

endpackage

// ==== cycle_timer.sv ====
`timescale 1ns/100ps

module cycle_timer (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         timecmp_write,
    input  logic                         timecmp_high,
    input  logic [machine_pkg::xlen-1:0] timecmp_data,
    output logic [63:0]                  cycles,
    output logic [63:0]                  timecmp,
    output logic                         mtip
);

    // free-running count, doubles as the time base for the compare
    always_ff @(posedge clock) begin
        if (reset) begin
            cycles <= '0;
        end else begin
            cycles <= cycles + 64'd1;
        end
    end

    // compare value is written one half per apb access
    // all ones after reset so the timer stays quiet until software arms it
    always_ff @(posedge clock) begin
        if (reset) begin
            timecmp <= '1;
        end else if (timecmp_write) begin
            if (timecmp_high) begin
                timecmp[63:32] <= timecmp_data;
            end else begin
                timecmp[31:0] <= timecmp_data;
            end
        end
    end

    // pending as long as the count has reached the compare value
    always_comb begin
        mtip = cycles >= timecmp;
    end

    // an unarmed compare must never fire
    mtip_quiet_unarmed: assert property (
        @(posedge clock) disable iff (reset)
        (&timecmp) |-> !$rose(mtip)
    ) else $error("timer interrupt raised while mtimecmp is all ones");

endmodule

// ==== csr_file.sv ====
`timescale 1ns/100ps

module csr_file (
    input  logic                         clock,
    input  logic                         reset,
    input  apb_pkg::apb_req_t            apb_req,
    output apb_pkg::apb_rsp_t            apb_rsp,
    input  machine_pkg::trap_update_t    update,
    input  logic                         irq,
    input  logic                         mtip,
    input  logic [63:0]                  cycles,
    input  logic [63:0]                  timecmp,
    output logic                         timecmp_write,
    output logic                         timecmp_high,
    output logic [machine_pkg::xlen-1:0] timecmp_data,
    output logic                         global_enable,
    output logic                         meie,
    output logic                         mtie,
    output logic [machine_pkg::xlen-1:0] mtvec,
    output logic [machine_pkg::xlen-1:0] mepc
);

    // access phase decode
    logic access;
    logic addr_valid;
    logic read_only;
    logic write_strobe;
    logic [machine_pkg::xlen-1:0] read_data;

    // interrupt enable stack in mstatus
    logic mstatus_mie;
    logic mstatus_mpie;

    // stored values, low bits of mtvec and mepc kept but never read
    logic [machine_pkg::xlen-1:0] mtvec_value;
    logic [machine_pkg::xlen-1:0] mepc_value;
    logic [machine_pkg::xlen-1:0] mscratch;
    machine_pkg::cause_t          mcause;

    // handler addresses are word aligned
    assign mtvec = {mtvec_value[machine_pkg::xlen-1:2], 2'b00};
    assign mepc  = {mepc_value[machine_pkg::xlen-1:2], 2'b00};
    assign global_enable = mstatus_mie;

    // address decode and read mux in one pass
    always_comb begin
        access     = apb_req.psel && apb_req.penable;
        addr_valid = 1'b1;
        read_only  = 1'b0;
        read_data  = '0;
        case (apb_req.paddr)
            machine_pkg::csr_mstatus: begin
                // mpp reads as machine mode
                read_data[12:11] = 2'b11;
                read_data[machine_pkg::mstatus_mpie_bit] = mstatus_mpie;
                read_data[machine_pkg::mstatus_mie_bit]  = mstatus_mie;
            end
            machine_pkg::csr_mie: begin
                read_data[machine_pkg::meie_bit] = meie;
                read_data[machine_pkg::mtie_bit] = mtie;
            end
            machine_pkg::csr_mip: begin
                // live pending lines, writes have no effect
                read_data[machine_pkg::meie_bit] = irq;
                read_data[machine_pkg::mtie_bit] = mtip;
            end
            machine_pkg::csr_mtvec:     read_data = mtvec;
            machine_pkg::csr_mscratch:  read_data = mscratch;
            machine_pkg::csr_mepc:      read_data = mepc;
            machine_pkg::csr_mcause: begin
                read_data[machine_pkg::interrupt_bit] = mcause.interrupt;
                read_data[3:0] = mcause.code;
            end
            machine_pkg::csr_mtimecmp:  read_data = timecmp[31:0];
            machine_pkg::csr_mtimecmph: read_data = timecmp[63:32];
            machine_pkg::csr_cycle: begin
                read_data = cycles[31:0];
                read_only = 1'b1;
            end
            machine_pkg::csr_cycleh: begin
                read_data = cycles[63:32];
                read_only = 1'b1;
            end
            default: addr_valid = 1'b0;
        endcase
    end

    // zero wait states, error on unknown address or write to a counter
    always_comb begin
        write_strobe    = access && apb_req.pwrite && addr_valid && !read_only;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && (!addr_valid || (apb_req.pwrite && read_only));
        apb_rsp.prdata  = (access && !apb_req.pwrite) ? read_data : '0;
    end

    // compare register lives in the timer
    assign timecmp_write = write_strobe && (apb_req.paddr == machine_pkg::csr_mtimecmp ||
                                            apb_req.paddr == machine_pkg::csr_mtimecmph);
    assign timecmp_high  = apb_req.paddr == machine_pkg::csr_mtimecmph;
    assign timecmp_data  = apb_req.pwdata;

    // control state, trap updates come last so they win over a bus write
    always_ff @(posedge clock) begin
        if (reset) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            meie         <= 1'b0;
            mtie         <= 1'b0;
            mtvec_value  <= machine_pkg::default_trap_vector;
        end else begin
            if (write_strobe && apb_req.paddr == machine_pkg::csr_mstatus) begin
                mstatus_mie  <= apb_req.pwdata[machine_pkg::mstatus_mie_bit];
                mstatus_mpie <= apb_req.pwdata[machine_pkg::mstatus_mpie_bit];
            end
            if (write_strobe && apb_req.paddr == machine_pkg::csr_mie) begin
                meie <= apb_req.pwdata[machine_pkg::meie_bit];
                mtie <= apb_req.pwdata[machine_pkg::mtie_bit];
            end
            if (write_strobe && apb_req.paddr == machine_pkg::csr_mtvec) begin
                mtvec_value <= apb_req.pwdata;
            end
            // push the enable stack on entry, pop it on mret
            if (update.enter) begin
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
            end else if (update.leave) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
            end
        end
    end

    // payload registers
    always_ff @(posedge clock) begin
        if (write_strobe && apb_req.paddr == machine_pkg::csr_mscratch) begin
            mscratch <= apb_req.pwdata;
        end
        if (write_strobe && apb_req.paddr == machine_pkg::csr_mepc) begin
            mepc_value <= apb_req.pwdata;
        end
        if (write_strobe && apb_req.paddr == machine_pkg::csr_mcause) begin
            mcause.interrupt <= apb_req.pwdata[machine_pkg::interrupt_bit];
            mcause.code      <= apb_req.pwdata[3:0];
        end
        // trap entry records where and why
        if (update.enter) begin
            mepc_value <= update.epc;
            mcause     <= update.cause;
        end
    end

    // access phase only ever follows a setup phase
    apb_setup_before_access: assert property (
        @(posedge clock) disable iff (reset)
        apb_req.penable |-> $past(apb_req.psel)
    ) else $error("apb penable high without psel in the previous cycle");

endmodule

// ==== trap_controller.sv ====
`timescale 1ns/100ps

module trap_controller (
    input  logic                         clock,
    input  logic                         reset,
    input  machine_pkg::core_event_t     core_event,
    input  logic                         irq,
    input  logic                         mtip,
    input  logic                         global_enable,
    input  logic                         meie,
    input  logic                         mtie,
    input  logic [machine_pkg::xlen-1:0] mtvec,
    input  logic [machine_pkg::xlen-1:0] mepc,
    output machine_pkg::trap_update_t    update,
    output machine_pkg::redirect_t       redirect,
    output logic                         locked
);

    machine_pkg::trap_state_t state;
    machine_pkg::trap_state_t next_state;

    // interrupts that pass both enables
    logic mei_pending;
    logic mti_pending;
    logic take_redirect;
    logic [machine_pkg::xlen-1:0] redirect_target;

    // one-cycle decision, priority mei, mti, exception, mret
    always_comb begin
        mei_pending     = global_enable && meie && irq;
        mti_pending     = global_enable && mtie && mtip;
        next_state      = state;
        take_redirect   = 1'b0;
        redirect_target = mtvec;
        update          = '0;
        update.epc      = core_event.pc;
        if (state != machine_pkg::locked) begin
            if (mei_pending || mti_pending) begin
                update.enter = 1'b1;
                update.cause.interrupt = 1'b1;
                update.cause.code = mei_pending ? machine_pkg::cause_mei : machine_pkg::cause_mti;
                take_redirect = 1'b1;
                next_state = machine_pkg::handler;
            end else if (core_event.exception_valid) begin
                if (state == machine_pkg::handler) begin
                    // fault inside a handler, freeze until reset
                    next_state = machine_pkg::locked;
                end else begin
                    update.enter = 1'b1;
                    update.cause.code = core_event.exception_code;
                    take_redirect = 1'b1;
                    next_state = machine_pkg::handler;
                end
            end else if (core_event.mret && state == machine_pkg::handler) begin
                // mret outside a handler has nothing to return to
                update.leave = 1'b1;
                take_redirect = 1'b1;
                redirect_target = mepc;
                next_state = machine_pkg::run;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= machine_pkg::run;
            redirect.valid <= 1'b0;
        end else begin
            state <= next_state;
            redirect.valid <= take_redirect;
        end
    end

    // target only matters while valid
    always_ff @(posedge clock) begin
        redirect.target <= redirect_target;
    end

    assign locked = state == machine_pkg::locked;

    trap_enter_leave_exclusive: assert property (
        @(posedge clock) disable iff (reset)
        !(update.enter && update.leave)
    ) else $error("trap entry and return in the same cycle");

endmodule

// ==== trap_csr_unit.sv ====
`timescale 1ns/100ps

module trap_csr_unit (
    input  logic                     clock,
    input  logic                     reset,
    input  apb_pkg::apb_req_t        apb_req,
    output apb_pkg::apb_rsp_t        apb_rsp,
    input  machine_pkg::core_event_t core_event,
    input  logic                     irq,
    output machine_pkg::redirect_t   redirect,
    output logic                     locked
);

    // timer side
    logic                         timecmp_write;
    logic                         timecmp_high;
    logic [machine_pkg::xlen-1:0] timecmp_data;
    logic [63:0]                  cycles;
    logic [63:0]                  timecmp;
    logic                         mtip;

    // csr state seen by the trap logic
    logic                         global_enable;
    logic                         meie;
    logic                         mtie;
    logic [machine_pkg::xlen-1:0] mtvec;
    logic [machine_pkg::xlen-1:0] mepc;
    machine_pkg::trap_update_t    update;

    cycle_timer u_cycle_timer (
        .clock         (clock),
        .reset         (reset),
        .timecmp_write (timecmp_write),
        .timecmp_high  (timecmp_high),
        .timecmp_data  (timecmp_data),
        .cycles        (cycles),
        .timecmp       (timecmp),
        .mtip          (mtip)
    );

    csr_file u_csr_file (
        .clock         (clock),
        .reset         (reset),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .update        (update),
        .irq           (irq),
        .mtip          (mtip),
        .cycles        (cycles),
        .timecmp       (timecmp),
        .timecmp_write (timecmp_write),
        .timecmp_high  (timecmp_high),
        .timecmp_data  (timecmp_data),
        .global_enable (global_enable),
        .meie          (meie),
        .mtie          (mtie),
        .mtvec         (mtvec),
        .mepc          (mepc)
    );

    // updates land in csr_file at the same edge the state moves
    trap_controller u_trap_controller (
        .clock         (clock),
        .reset         (reset),
        .core_event    (core_event),
        .irq           (irq),
        .mtip          (mtip),
        .global_enable (global_enable),
        .meie          (meie),
        .mtie          (mtie),
        .mtvec         (mtvec),
        .mepc          (mepc),
        .update        (update),
        .redirect      (redirect),
        .locked        (locked)
    );

endmodule

// ==== tb_tests.svh ====
// handler base and the pcs the core reports
localparam logic [31:0] handler_base = 32'h0000_0200;
localparam logic [31:0] irq_pc       = 32'h0000_1A40;
localparam logic [31:0] exception_pc = 32'h0000_2C08;
localparam logic [31:0] timer_pc     = 32'h0000_3F10;

// mstatus as read back, mpp fixed at machine mode
function automatic logic [31:0] expected_mstatus(input logic mie, input logic mpie);
    return 32'h0000_1800 | (32'(mpie) << 7) | (32'(mie) << 3);
endfunction

task automatic apply_reset();
    @(negedge clock);
    reset      = 1'b1;
    apb_req    = '0;
    core_event = '0;
    irq        = 1'b0;
    repeat (reset_cycles) @(negedge clock);
    reset = 1'b0;
endtask

// setup then access phase, response sampled mid access cycle
task automatic apb_transfer(input logic write, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
    @(negedge clock);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clock);
    apb_req.penable = 1'b1;
    #1;
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    // no wait states, so the access cycle is always ready
    check_value("apb pready", 1, apb_rsp.pready);
    @(negedge clock);
    apb_req = '0;
endtask

task automatic read_check(input string test_name, input logic [11:0] addr,
                          input logic [31:0] expected);
    logic [31:0] rdata;
    logic        slverr;
    apb_transfer(1'b0, addr, '0, rdata, slverr);
    check_value({test_name, " pslverr"}, 0, slverr);
    check_value(test_name, expected, rdata);
endtask

task automatic write_csr(input string test_name, input logic [11:0] addr,
                         input logic [31:0] data);
    logic [31:0] rdata;
    logic        slverr;
    apb_transfer(1'b1, addr, data, rdata, slverr);
    check_value({test_name, " pslverr"}, 0, slverr);
endtask

// core holds the event for one cycle, redirect shows up in the next
task automatic pulse_event(input logic exc, input logic [3:0] code, input logic mret,
                           input logic [31:0] pc);
    @(negedge clock);
    core_event.exception_valid = exc;
    core_event.exception_code  = code;
    core_event.mret            = mret;
    core_event.pc              = pc;
    @(negedge clock);
    core_event.exception_valid = 1'b0;
    core_event.mret            = 1'b0;
endtask

task automatic check_redirect(input string test_name, input logic [31:0] target);
    check_value({test_name, " valid"}, 1, redirect.valid);
    check_value({test_name, " target"}, target, redirect.target);
endtask

task automatic check_quiet(input string test_name, input int num_cycles);
    repeat (num_cycles) begin
        @(negedge clock);
        check_value(test_name, 0, redirect.valid);
    end
endtask

// polls redirect on falling edges up to a limit
task automatic wait_redirect(input int max_cycles, output logic seen);
    seen = 1'b0;
    for (int i = 0; i < max_cycles && !seen; i++) begin
        @(negedge clock);
        seen = redirect.valid;
    end
endtask

task automatic reset_test();
    logic [31:0] rdata;
    logic        slverr;
    read_check("reset mstatus", machine_pkg::csr_mstatus, expected_mstatus(0, 0));
    read_check("reset mie", machine_pkg::csr_mie, 32'h0);
    read_check("reset mtvec", machine_pkg::csr_mtvec, machine_pkg::default_trap_vector);
    check_value("reset locked", 0, locked);
    check_quiet("reset redirect", 4);
    apb_transfer(1'b0, 12'h123, '0, rdata, slverr);
    check_value("unlisted read pslverr", 1, slverr);
    check_value("unlisted read data", 0, rdata);
    apb_transfer(1'b1, machine_pkg::csr_cycle, 32'h5, rdata, slverr);
    check_value("cycle write pslverr", 1, slverr);
endtask

task automatic register_test();
    logic [31:0] value;
    logic [31:0] first;
    logic [31:0] second;
    logic        slverr;
    repeat (4) begin
        value = $urandom;
        write_csr("mscratch write", machine_pkg::csr_mscratch, value);
        read_check("mscratch readback", machine_pkg::csr_mscratch, value);
    end
    // low bits written but read as zero
    write_csr("mtvec write", machine_pkg::csr_mtvec, handler_base | 32'h3);
    read_check("mtvec readback", machine_pkg::csr_mtvec, handler_base);
    apb_transfer(1'b0, machine_pkg::csr_cycle, '0, first, slverr);
    apb_transfer(1'b0, machine_pkg::csr_cycle, '0, second, slverr);
    if (second <= first) begin
        error_count++;
        $display("register test: cycle did not grow between reads (%0d then %0d)",
                 first, second);
    end
endtask

task automatic external_irq_test();
    write_csr("irq mie", machine_pkg::csr_mie, 32'h1 << machine_pkg::meie_bit);
    write_csr("irq mstatus", machine_pkg::csr_mstatus, 32'h1 << machine_pkg::mstatus_mie_bit);
    @(negedge clock);
    irq           = 1'b1;
    core_event.pc = irq_pc;
    @(negedge clock);
    irq = 1'b0;
    check_redirect("irq redirect", handler_base);
    read_check("irq mepc", machine_pkg::csr_mepc, irq_pc);
    read_check("irq mcause", machine_pkg::csr_mcause, 32'h8000_000B);
    read_check("irq mstatus", machine_pkg::csr_mstatus, expected_mstatus(0, 1));
endtask

task automatic mret_test();
    pulse_event(1'b0, 4'd0, 1'b1, exception_pc);
    check_redirect("mret redirect", irq_pc);
    read_check("mret mstatus", machine_pkg::csr_mstatus, expected_mstatus(1, 1));
    pulse_event(1'b1, 4'd2, 1'b0, exception_pc);
    check_redirect("exception redirect", handler_base);
    read_check("exception mcause", machine_pkg::csr_mcause, 32'd2);
    read_check("exception mepc", machine_pkg::csr_mepc, exception_pc);
    // back to run before the timer is armed
    pulse_event(1'b0, 4'd0, 1'b1, exception_pc);
    check_redirect("exception return", exception_pc);
endtask

task automatic timer_test();
    logic [31:0] now;
    logic        slverr;
    logic        seen;
    apb_transfer(1'b0, machine_pkg::csr_cycle, '0, now, slverr);
    write_csr("timer mtimecmp", machine_pkg::csr_mtimecmp, now + 32'd40);
    write_csr("timer mtimecmph", machine_pkg::csr_mtimecmph, 32'h0);
    core_event.pc = timer_pc;
    write_csr("timer mie", machine_pkg::csr_mie,
              (32'h1 << machine_pkg::mtie_bit) | (32'h1 << machine_pkg::meie_bit));
    wait_redirect(60, seen);
    if (!seen) begin
        error_count++;
        $display("timer test: no redirect within 60 cycles after arming mtimecmp");
    end
    check_value("timer redirect target", handler_base, redirect.target);
    read_check("timer mcause", machine_pkg::csr_mcause, 32'h8000_0007);
    read_check("timer mepc", machine_pkg::csr_mepc, timer_pc);
    // irq joins the pending timer, both fire once mret reopens mie
    @(negedge clock);
    irq = 1'b1;
    pulse_event(1'b0, 4'd0, 1'b1, timer_pc);
    check_redirect("timer return", timer_pc);
    wait_redirect(2, seen);
    if (!seen) begin
        error_count++;
        $display("timer test: no trap taken with irq and timer both pending");
    end
    read_check("both pending mcause", machine_pkg::csr_mcause, 32'h8000_000B);
    irq = 1'b0;
endtask

task automatic lockup_test();
    apply_reset();
    pulse_event(1'b1, 4'd5, 1'b0, exception_pc);
    check_redirect("lockup first exception", machine_pkg::default_trap_vector);
    // second fault while the handler runs
    pulse_event(1'b1, 4'd7, 1'b0, exception_pc + 32'd4);
    check_value("lockup nested exception redirect", 0, redirect.valid);
    check_value("lockup locked", 1, locked);
    pulse_event(1'b0, 4'd0, 1'b1, exception_pc);
    check_value("locked mret redirect", 0, redirect.valid);
    write_csr("locked mie", machine_pkg::csr_mie, 32'h1 << machine_pkg::meie_bit);
    write_csr("locked mstatus", machine_pkg::csr_mstatus, 32'h1 << machine_pkg::mstatus_mie_bit);
    irq = 1'b1;
    check_quiet("locked irq redirect", 5);
    irq = 1'b0;
    check_value("still locked", 1, locked);
    apply_reset();
    check_value("reset clears locked", 0, locked);
endtask

// ==== tb_trap_csr_unit.sv ====
`timescale 1ns/100ps

module tb_trap_csr_unit;

    localparam int clock_period = 10;
    localparam int reset_cycles = 5;

    // cycles per test in run order, the timer test carries its 60 cycle wait
    localparam int test_cycles = 30 + 40 + 25 + 25 + 100 + 40;
    // two resets inside the tests plus the first, doubled work, fixed margin
    localparam int budget_cycles = 3 * reset_cycles + 2 * test_cycles + 100;

    logic                     clock;
    logic                     reset;
    apb_pkg::apb_req_t        apb_req;
    apb_pkg::apb_rsp_t        apb_rsp;
    machine_pkg::core_event_t core_event;
    logic                     irq;
    machine_pkg::redirect_t   redirect;
    logic                     locked;

    int error_count = 0;
    int check_count = 0;

    trap_csr_unit dut (
        .clock      (clock),
        .reset      (reset),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .core_event (core_event),
        .irq        (irq),
        .redirect   (redirect),
        .locked     (locked)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // one comparison, a mismatch is reported on the spot
    task automatic check_value(input string test_name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("FAILED %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    `include "tb_tests.svh"

    // stops a run that hangs on a missing response
    initial begin
        #(budget_cycles * clock_period);
        $display("timeout: tests still running after %0d cycles", budget_cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin : main
        int unsigned seed_value;
        seed_value = $urandom(22911);
        reset      = 1'b1;
        apb_req    = '0;
        core_event = '0;
        irq        = 1'b0;
        apply_reset();

        reset_test();
        register_test();
        external_irq_test();
        mret_test();
        timer_test();
        lockup_test();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
machine_pkg.sv
apb_pkg.sv
cycle_timer.sv
csr_file.sv
trap_controller.sv
trap_csr_unit.sv
tb_trap_csr_unit.sv

// ==== Bender.yml ====
package:
  name: trap_csr_unit

sources:
  - machine_pkg.sv
  - apb_pkg.sv
  - cycle_timer.sv
  - csr_file.sv
  - trap_controller.sv
  - trap_csr_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_trap_csr_unit.sv
